//--- Makefile
VERILATOR ?= verilator
TOP       ?= ifu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "No pass line found"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bht.sv
`timescale 1ns/1ps
`default_nettype none

module bht (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   fetch_req,
    input  fetch_pkg::addr_t       fetch_pc,
    input  fetch_pkg::bru_update_t bru_update,
    output fetch_pkg::bht_line_t   bht_read_data
);
    import fetch_pkg::*;

    bht_line_t              ctr_mem [TABLE_LINES];  // Four counters per line
    logic [TABLE_IDX_W-1:0] rd_idx;
    logic [TABLE_IDX_W-1:0] wr_idx;
    logic [1:0]             wr_slot;                // Counter within the line
    logic [1:0]             old_ctr;
    logic [1:0]             new_ctr;
    bht_line_t              wr_line;                // Line with trained counter merged in

    assign rd_idx  = fetch_pc[4 +: TABLE_IDX_W];
    assign wr_idx  = bru_update.pc[4 +: TABLE_IDX_W];
    assign wr_slot = bru_update.pc[3:2];

    // Saturating 2-bit update
    always_comb begin
        wr_line = ctr_mem[wr_idx];
        old_ctr = wr_line[{wr_slot, 1'b0} +: 2];
        new_ctr = old_ctr;
        if (bru_update.taken) begin
            if (old_ctr != 2'b11) new_ctr = old_ctr + 2'd1;  // Stop at strongly taken
        end else begin
            if (old_ctr != 2'b00) new_ctr = old_ctr - 2'd1;  // Stop at strongly not taken
        end
        wr_line[{wr_slot, 1'b0} +: 2] = new_ctr;
    end

    // Counter array, all weakly not taken out of reset
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TABLE_LINES; i++) begin
                ctr_mem[i] <= {FETCH_SLOTS{CTR_RESET}};
            end
        end else if (bru_update.valid) begin
            ctr_mem[wr_idx] <= wr_line;
        end
    end

    // Line read, ready in the fetch_done cycle
    always_ff @(posedge clock) begin
        if (fetch_req) begin
            bht_read_data <= ctr_mem[rd_idx];  // Same-edge write shows on next read
        end
    end

endmodule

`default_nettype wire

//--- btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   fetch_req,
    input  fetch_pkg::addr_t       fetch_pc,
    input  fetch_pkg::bru_update_t bru_update,
    output fetch_pkg::btb_line_t   btb_targets
);
    import fetch_pkg::*;

    btb_line_t              tgt_mem [TABLE_LINES];  // No tags, direct-mapped
    logic [TABLE_IDX_W-1:0] rd_idx;
    logic [TABLE_IDX_W-1:0] wr_idx;
    logic [1:0]             wr_slot;
    logic                   wr_en;
    btb_line_t              wr_line;

    assign rd_idx  = fetch_pc[4 +: TABLE_IDX_W];
    assign wr_idx  = bru_update.pc[4 +: TABLE_IDX_W];
    assign wr_slot = bru_update.pc[3:2];
    assign wr_en   = bru_update.valid && bru_update.taken;  // Not-taken leaves target alone

    // Merge new target into its slot
    always_comb begin
        wr_line = tgt_mem[wr_idx];
        wr_line[{wr_slot, 5'b0} +: 32] = bru_update.target;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TABLE_LINES; i++) begin
                tgt_mem[i] <= '0;  // All targets zero
            end
        end else if (wr_en) begin
            tgt_mem[wr_idx] <= wr_line;
        end
    end

    // Registered line read on the request
    always_ff @(posedge clock) begin
        if (fetch_req) begin
            btb_targets <= tgt_mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Fetch geometry
    localparam int FETCH_SLOTS = 4;           // Instructions per cache line
    localparam int LINE_BYTES  = 16;          // One line per fetch
    localparam int TABLE_LINES = 64;          // Predictor depth
    localparam int TABLE_IDX_W = 6;           // Index taken from pc[9:4]

    // RV32I control-flow opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [1:0]  CTR_RESET = 2'b01;                  // Weakly not taken
    localparam logic [63:0] RESET_PC  = 64'h0000_0000_8000_0000; // Boot address

    typedef logic [63:0]                addr_t;
    typedef logic [31:0]                target_t;     // Zero-extended into the PC
    typedef logic [31:0]                instr_t;
    typedef logic [FETCH_SLOTS*32-1:0]  fetch_line_t; // Slot 0 in the low bits
    typedef logic [FETCH_SLOTS-1:0]     slot_mask_t;
    typedef logic [FETCH_SLOTS*2-1:0]   bht_line_t;   // Counter k at [2k+1:2k]
    typedef logic [FETCH_SLOTS*32-1:0]  btb_line_t;   // Targets in slot order

    // One resolved control-flow instruction from the backend
    typedef struct packed {
        logic    valid;
        addr_t   pc;
        logic    taken;
        target_t target;
    } bru_update_t;

    // Aligned and trimmed line for the instruction buffer
    typedef struct packed {
        fetch_line_t instr;
        slot_mask_t  valid;
        slot_mask_t  predict_taken;
        btb_line_t   predict_target;
    } ib_bundle_t;

    typedef enum logic {
        PC_ISSUE,   // Ready to send a request
        PC_WAIT     // One fetch outstanding
    } pc_state_t;

endpackage

`default_nettype wire

//--- files.f
fetch_pkg.sv
bht.sv
btb.sv
instr_admin.sv
pc_ctrl.sv
ifu_top.sv
ifu_sva.sv
ifu_tb.sv

//--- ifu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_sva (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  fetch_req,
    input logic                  fetch_done,
    input logic                  ib_stall,
    input fetch_pkg::ib_bundle_t ib_out
);
    import fetch_pkg::*;

    // Cache answers exactly one cycle later
    a_done_follows: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_req |=> fetch_done) else $error("fetch_done missing after fetch_req");

    a_done_source: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_done |-> $past(fetch_req)) else $error("fetch_done without fetch_req");

    a_stall_quiet: assert property (@(posedge clock) disable iff (!rst_n)
        ib_stall |-> !fetch_req) else $error("fetch_req under ib_stall");

    a_idle_valid: assert property (@(posedge clock) disable iff (!rst_n)
        !fetch_done |-> ib_out.valid == '0) else $error("ib_out valid while idle");

    // One run of ones, no holes
    a_contiguous: assert property (@(posedge clock) disable iff (!rst_n)
        ib_out.valid inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hc,
                             4'h7, 4'he, 4'hf})
        else $error("ib_out valid mask not contiguous");

    a_pred_subset: assert property (@(posedge clock) disable iff (!rst_n)
        (ib_out.predict_taken & ~ib_out.valid) == '0)
        else $error("predict_taken outside valid");

endmodule

bind ifu_top ifu_sva u_sva (
    .clock      (clock),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_done (fetch_done),
    .ib_stall   (ib_stall),
    .ib_out     (ib_out)
);

`default_nettype wire

//--- ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;
    import fetch_pkg::*;

    localparam logic [31:0] SEED    = 32'h476a_4e8b;
    localparam int          TIMEOUT = 50;              // Cycles per wait
    localparam logic [31:0] W_JAL   = 32'h0000_006f;
    localparam logic [31:0] W_BR    = 32'h0000_0063;
    localparam logic [31:0] W_ADD   = 32'h0000_0033;

    logic        clock;
    logic        rst_n;
    logic        fetch_req;
    addr_t       fetch_pc;
    logic        fetch_done;
    fetch_line_t fetch_instr;
    logic        ib_stall;
    logic        redirect_valid;
    addr_t       redirect_pc;
    bru_update_t bru_update;
    ib_bundle_t  ib_out;

    logic [7:0]  mem [1024];                           // Cache bytes, pc[9:0]
    logic [1:0]  shadow_ctr [TABLE_LINES][FETCH_SLOTS];
    target_t     shadow_tgt [TABLE_LINES][FETCH_SLOTS];
    logic        req_q;                                // Request seen at last edge
    addr_t       req_pc_q;
    int          n_pass;
    int          n_fail;
    logic        test_bad;

    ifu_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Cache model answers one cycle after the request
    always @(posedge clock) begin
        req_q    <= fetch_req;
        req_pc_q <= fetch_pc;
    end

    always @(negedge clock) begin
        fetch_done = req_q;
        for (int b = 0; b < LINE_BYTES; b++) begin
            fetch_instr[b*8 +: 8] = mem[{req_pc_q[9:4], 4'(b)}];
        end
    end

    function automatic logic [31:0] word_at(logic [9:0] a);
        return {mem[{a[9:2], 2'd3}], mem[{a[9:2], 2'd2}],
                mem[{a[9:2], 2'd1}], mem[{a[9:2], 2'd0}]};
    endfunction

    task automatic put_word(addr_t a, logic [31:0] w);
        for (int b = 0; b < 4; b++) mem[{a[9:2], 2'(b)}] = w[b*8 +: 8];
    endtask

    // Expected bundle, aligned and cut after the first taken control-flow slot
    task automatic predict(addr_t pc, output ib_bundle_t b, output addr_t nxt);
        int          src;
        logic [31:0] w;
        logic        stop;
        stop = 1'b0;
        b    = '0;
        nxt  = {pc[63:4], 4'b0} + 64'd16;
        for (int s = 0; s < FETCH_SLOTS; s++) begin
            src = s + int'(pc[3:2]);
            if (src < FETCH_SLOTS && !stop) begin
                w = word_at({pc[9:4], 2'(src), 2'b00});
                b.valid[s] = 1'b1;
                b.instr[s*32 +: 32] = w;
                if ((w[6:0] == OPC_JAL || w[6:0] == OPC_JALR || w[6:0] == OPC_BRANCH)
                    && shadow_ctr[pc[9:4]][src][1]) begin
                    b.predict_taken[s] = 1'b1;
                    b.predict_target[s*32 +: 32] = shadow_tgt[pc[9:4]][src];
                    nxt  = {32'b0, shadow_tgt[pc[9:4]][src]};
                    stop = 1'b1;
                end
            end
        end
    endtask

    task automatic check(string name, logic [263:0] exp, logic [263:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic end_test(string name);
        if (test_bad) n_fail++;
        else n_pass++;
        $display("%s %s", test_bad ? "FAILED" : "PASSED", name);
        test_bad = 1'b0;
    endtask

    task automatic wait_sig(string name, logic want_done);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            #1;
            n++;
        end while (!(want_done ? fetch_done : fetch_req) && n < TIMEOUT);
        if (n >= TIMEOUT) begin
            $display("ERROR %s: no %s within %0d cycles", name,
                     want_done ? "fetch_done" : "fetch_req", TIMEOUT);
            test_bad = 1'b1;
        end
    endtask

    task automatic redirect(addr_t pc);
        @(negedge clock);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clock);
        redirect_valid = 1'b0;
    endtask

    task automatic train(addr_t pc, logic taken, target_t tgt);
        logic [1:0] c;
        @(negedge clock);
        bru_update = '{valid: 1'b1, pc: pc, taken: taken, target: tgt};
        @(negedge clock);
        bru_update.valid = 1'b0;
        c = shadow_ctr[pc[9:4]][pc[3:2]];
        if (taken && c != 2'd3) c++;
        if (!taken && c != 2'd0) c--;
        shadow_ctr[pc[9:4]][pc[3:2]] = c;
        if (taken) shadow_tgt[pc[9:4]][pc[3:2]] = tgt;
    endtask

    // One fetch of pc and the request address after it
    task automatic do_fetch(string name, addr_t pc);
        ib_bundle_t exp;
        addr_t      nxt;
        predict(pc, exp, nxt);
        wait_sig(name, 1'b1);
        check({name, " pc"}, 264'(pc), 264'(fetch_pc));
        check({name, " ib_out"}, exp, ib_out);
        wait_sig(name, 1'b0);
        check({name, " next_pc"}, 264'(nxt), 264'(fetch_pc));
    endtask

    initial begin
        #2ms;
        $display("ERROR: simulation watchdog expired");
        $display("Test failed");
        $finish;
    end

    initial begin
        int len;
        void'($urandom(SEED));
        rst_n          = 1'b0;
        ib_stall       = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        bru_update     = '0;
        fetch_done     = 1'b0;
        fetch_instr    = '0;
        req_q          = 1'b0;
        req_pc_q       = '0;
        n_pass         = 0;
        n_fail         = 0;
        test_bad       = 1'b0;
        for (int i = 0; i < 1024; i++) mem[i] = 8'($urandom);
        for (int i = 0; i < TABLE_LINES; i++) begin
            for (int k = 0; k < FETCH_SLOTS; k++) begin
                shadow_ctr[i][k] = CTR_RESET;
                shadow_tgt[i][k] = '0;
            end
        end
        // Known slots for the prediction tests
        for (int k = 0; k < 4; k++) begin
            put_word(RESET_PC + 64'h200 + 64'(4*k), k == 1 ? W_BR : W_ADD);
        end
        for (int k = 0; k < 4; k++) put_word(RESET_PC + 64'h280 + 64'(4*k), W_ADD);
        put_word(RESET_PC + 64'h300, W_ADD);
        put_word(RESET_PC + 64'h304, W_JAL);
        put_word(RESET_PC + 64'h308, W_ADD);
        put_word(RESET_PC + 64'h30c, W_BR);

        repeat (10) begin
            @(negedge clock);
            #1;
            check("reset fetch_req", 264'(0), 264'(fetch_req));
            check("reset valid", 264'(0), 264'(ib_out.valid));
        end
        rst_n = 1'b1;
        do_fetch("reset_fetch", RESET_PC);
        end_test("reset");

        for (int off = 0; off < 4; off++) begin
            redirect(RESET_PC + 64'h100 + 64'(4*off));
            do_fetch($sformatf("align_off%0d", off), RESET_PC + 64'h100 + 64'(4*off));
        end
        end_test("alignment");

        train(RESET_PC + 64'h204, 1'b1, 32'h8000_0340);
        train(RESET_PC + 64'h204, 1'b1, 32'h8000_0340);
        redirect(RESET_PC + 64'h200);
        do_fetch("branch_pred", RESET_PC + 64'h200);
        end_test("train_predict");

        train(RESET_PC + 64'h288, 1'b1, 32'h8000_0380);
        train(RESET_PC + 64'h288, 1'b1, 32'h8000_0380);
        redirect(RESET_PC + 64'h280);
        do_fetch("non_cf", RESET_PC + 64'h280);
        end_test("non_control_flow");

        train(RESET_PC + 64'h304, 1'b1, 32'h8000_0040);
        train(RESET_PC + 64'h304, 1'b1, 32'h8000_0040);
        train(RESET_PC + 64'h30c, 1'b1, 32'h8000_0080);
        train(RESET_PC + 64'h30c, 1'b1, 32'h8000_0080);
        redirect(RESET_PC + 64'h300);
        do_fetch("two_pred", RESET_PC + 64'h300);
        end_test("first_taken");

        redirect(RESET_PC + 64'h100);
        wait_sig("redir", 1'b0);
        redirect(RESET_PC + 64'h280);      // Lands while the fetch is outstanding
        do_fetch("redir", RESET_PC + 64'h280);
        for (int r = 0; r < 4; r++) begin
            len = 1 + int'($urandom % 8);
            @(negedge clock);
            ib_stall = 1'b1;
            repeat (len) begin
                @(negedge clock);
                #1;
                check("stall fetch_req", 264'(0), 264'(fetch_req));
            end
            ib_stall = 1'b0;
            wait_sig("stall release", 1'b0);
        end
        end_test("control");

        $display("Tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
    input  logic                   clock,
    input  logic                   rst_n,
    output logic                   fetch_req,
    output fetch_pkg::addr_t       fetch_pc,
    input  logic                   fetch_done,
    input  fetch_pkg::fetch_line_t fetch_instr,
    input  logic                   ib_stall,
    input  logic                   redirect_valid,
    input  fetch_pkg::addr_t       redirect_pc,
    input  fetch_pkg::bru_update_t bru_update,
    output fetch_pkg::ib_bundle_t  ib_out
);
    import fetch_pkg::*;

    bht_line_t bht_read_data;      // Counters for the fetched line
    btb_line_t btb_targets;        // Targets for the fetched line
    logic      pc_predict_taken;
    target_t   pc_predict_target;

    pc_ctrl u_pc_ctrl (
        .clock             (clock),
        .rst_n             (rst_n),
        .ib_stall          (ib_stall),
        .redirect_valid    (redirect_valid),
        .fetch_done        (fetch_done),
        .pc_predict_taken  (pc_predict_taken),
        .redirect_pc       (redirect_pc),
        .pc_predict_target (pc_predict_target),
        .fetch_req         (fetch_req),
        .fetch_pc          (fetch_pc)
    );

    bht u_bht (
        .clock         (clock),
        .rst_n         (rst_n),
        .fetch_req     (fetch_req),
        .fetch_pc      (fetch_pc),
        .bru_update    (bru_update),
        .bht_read_data (bht_read_data)
    );

    btb u_btb (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .bru_update  (bru_update),
        .btb_targets (btb_targets)
    );

    // Zero-latency path from fetch_done to ib_out
    instr_admin u_instr_admin (
        .fetch_done        (fetch_done),
        .fetch_pc          (fetch_pc),
        .fetch_instr       (fetch_instr),
        .bht_read_data     (bht_read_data),
        .btb_targets       (btb_targets),
        .ib_out            (ib_out),
        .pc_predict_taken  (pc_predict_taken),
        .pc_predict_target (pc_predict_target)
    );

endmodule

`default_nettype wire

//--- instr_admin.sv
`timescale 1ns/1ps
`default_nettype none

module instr_admin (
    input  logic                  fetch_done,
    input  fetch_pkg::addr_t      fetch_pc,
    input  fetch_pkg::fetch_line_t fetch_instr,
    input  fetch_pkg::bht_line_t  bht_read_data,
    input  fetch_pkg::btb_line_t  btb_targets,
    output fetch_pkg::ib_bundle_t ib_out,
    output logic                  pc_predict_taken,
    output fetch_pkg::target_t    pc_predict_target
);
    import fetch_pkg::*;

    logic [1:0]  slot_off;       // First useful slot in the line
    fetch_line_t aligned_instr;
    slot_mask_t  aligned_valid;
    bht_line_t   aligned_ctr;    // Counters follow their instructions
    btb_line_t   aligned_tgt;    // Targets too
    slot_mask_t  cf_slot;        // JAL, JALR or branch
    slot_mask_t  hist_taken;     // Counter upper bits
    slot_mask_t  pred_slot;      // Real control flow predicted taken
    slot_mask_t  keep_mask;      // Slots up to the first prediction
    slot_mask_t  trim_valid;
    slot_mask_t  kept_pred;      // Only the first prediction survives

    function automatic logic is_ctrl_flow(instr_t instr);
        logic [6:0] opcode;
        opcode = instr[6:0];
        return (opcode == OPC_JAL) || (opcode == OPC_JALR) || (opcode == OPC_BRANCH);
    endfunction

    assign slot_off = fetch_pc[3:2];

    // Aligner, drops slots in front of the PC
    always_comb begin
        aligned_instr = '0;
        aligned_valid = '0;
        aligned_ctr   = '0;
        aligned_tgt   = '0;
        if (fetch_done) begin
            aligned_instr = fetch_instr >> {slot_off, 5'b0};
            aligned_tgt   = btb_targets >> {slot_off, 5'b0};
            aligned_ctr   = bht_read_data >> {slot_off, 1'b0};
            aligned_valid = {FETCH_SLOTS{1'b1}} >> slot_off;  // e.g. offset 1 gives 0111
        end
    end

    // Branch checker per slot
    always_comb begin
        for (int k = 0; k < FETCH_SLOTS; k++) begin
            cf_slot[k]    = is_ctrl_flow(aligned_instr[k*32 +: 32]);
            hist_taken[k] = aligned_ctr[2*k+1];
        end
    end

    assign pred_slot = cf_slot & hist_taken & aligned_valid;  // Empty slots never predict

    // Priority encoder, lowest predicted slot ends the line
    always_comb begin
        logic found;
        found     = 1'b0;
        keep_mask = '0;
        for (int k = 0; k < FETCH_SLOTS; k++) begin
            keep_mask[k] = !found;        // Predicted slot itself is kept
            if (pred_slot[k]) found = 1'b1;
        end
    end

    assign trim_valid = aligned_valid & keep_mask;
    assign kept_pred  = pred_slot & trim_valid;  // One-hot or zero

    // Outputs to instruction buffer and PC controller
    always_comb begin
        ib_out            = '0;
        pc_predict_target = '0;
        ib_out.valid         = trim_valid;
        ib_out.predict_taken = kept_pred;
        for (int k = 0; k < FETCH_SLOTS; k++) begin
            if (trim_valid[k]) begin
                ib_out.instr[k*32 +: 32] = aligned_instr[k*32 +: 32];
            end
            if (kept_pred[k]) begin
                ib_out.predict_target[k*32 +: 32] = aligned_tgt[k*32 +: 32];
                pc_predict_target = aligned_tgt[k*32 +: 32];  // At most one hit
            end
        end
    end

    assign pc_predict_taken = |pred_slot;

endmodule

`default_nettype wire

//--- pc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               ib_stall,
    input  logic               redirect_valid,
    input  logic               fetch_done,
    input  logic               pc_predict_taken,
    input  fetch_pkg::addr_t   redirect_pc,
    input  fetch_pkg::target_t pc_predict_target,
    output logic               fetch_req,
    output fetch_pkg::addr_t   fetch_pc
);
    import fetch_pkg::*;

    pc_state_t state_q;
    pc_state_t state_d;
    addr_t     pc_q;
    addr_t     pc_d;
    addr_t     line_next;   // Base of the following line
    logic      live_q;      // Goes high one cycle after reset release

    assign line_next = (pc_q & ~addr_t'(LINE_BYTES - 1)) + addr_t'(LINE_BYTES);

    // Redirect blocks a request in its own cycle
    assign fetch_req = live_q && (state_q == PC_ISSUE) && !ib_stall && !redirect_valid;
    assign fetch_pc  = pc_q;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        if (redirect_valid) begin
            state_d = PC_ISSUE;     // Pending fetch_done is dropped
            pc_d    = redirect_pc;
        end else begin
            case (state_q)
                PC_ISSUE: if (fetch_req) state_d = PC_WAIT;
                PC_WAIT: begin
                    if (fetch_done) begin
                        state_d = PC_ISSUE;
                        pc_d    = pc_predict_taken ? addr_t'(pc_predict_target) : line_next;
                    end
                end
                default: state_d = PC_ISSUE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PC_ISSUE;
            pc_q    <= RESET_PC;
            live_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            live_q  <= 1'b1;
        end
    end

endmodule

`default_nettype wire
